/* Makefile */
# Verilator build and run for the GPU front end testbench
VERILATOR ?= verilator
TOP       ?= gpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All checks passed
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+source
source/gpu_pkg.sv
source/gp0_fifo.sv
source/gp0_decoder.sv
source/vram_fill.sv
source/gpu_control.sv
source/gpu_top.sv
verif/gpu_tb.sv

/* source/gp0_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module gp0_decoder import gpu_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   clear_fifo,  // Back to IDLE
   input  wire logic                   soft_rst,    // GP1 reset
   input  wire logic [`GPU_WORD_W-1:0] head,
   input  wire logic                   not_empty,
   output logic                        pop,
   output logic                        irq_req,     // Pulse on GP0 1F
   output draw_env_t                   draw_env,
   output fill_job_t                   job,
   output logic                        job_valid,
   input  wire logic                   job_ready
);
   typedef enum logic [1:0] {IDLE, FILL_XY, FILL_WH} state_t;

   state_t              state;
   logic [7:0]          op;
   logic [14:0]         color_q;                   // Colour of the pending fill
   logic [`GPU_X_W-1:0] x_q;
   logic [`GPU_Y_W-1:0] y_q;

   assign op = head[31:24];

   // Third fill word stays at the FIFO head until the fill engine takes it
   assign job_valid = (state == FILL_WH) & not_empty;
   assign pop       = not_empty & ((state != FILL_WH) | job_ready);
   assign irq_req   = (state == IDLE) & not_empty & (op == `GP0_INTREQ);
   assign job       = '{x:      x_q,
                        y:      y_q,
                        width:  head[9:0],
                        height: head[24:16],
                        color:  color_q};

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state <= IDLE;
      end else if (clear_fifo) begin
         state <= IDLE;                            // Drop a half-read fill
      end else if (pop) begin
         case (state)
            IDLE:    if (op == `GP0_FILRECT) state <= FILL_XY;
            FILL_XY: state <= FILL_WH;
            default: state <= IDLE;                // Job handed over
         endcase
      end
   end

   // Environment registers, one-word commands only
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         draw_env <= '0;
      end else if (soft_rst) begin
         draw_env.draw_bits <= '0;                 // Area and offset survive
         draw_env.text_off  <= 1'b0;
         draw_env.set_mask  <= 1'b0;
         draw_env.mask_en   <= 1'b0;
      end else if (pop && state == IDLE) begin
         case (op)
            `GP0_DRWMODE: begin
               draw_env.draw_bits <= head[10:0];
               draw_env.text_off  <= head[11];
            end
            `GP0_MSK: begin
               draw_env.set_mask <= head[0];
               draw_env.mask_en  <= head[1];
            end
            `GP0_DRWWND_TL: draw_env.area_tl <= head[19:0]; // y in 19:10, x in 9:0
            `GP0_DRWWND_BR: draw_env.area_br <= head[19:0];
            `GP0_DRWWND_OS: draw_env.offset  <= head[21:0]; // y in 21:11
            `GP0_NOP:       ;
            default:        ;                      // irq and fill handled elsewhere
         endcase
      end
   end

   // Fill parameters gathered word by word
   always_ff @(posedge clk) begin
      if (pop) begin
         case (state)
            IDLE: begin
               if (op == `GP0_FILRECT) begin
                  color_q <= {head[23:19], head[15:11], head[7:3]}; // 24 to 15 bit
               end
            end
            FILL_XY: begin
               x_q <= head[9:0];
               y_q <= head[24:16];
            end
            default: ;
         endcase
      end
   end

endmodule
`default_nettype wire

/* source/gp0_fifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module gp0_fifo (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   to_gp0,      // One-cycle write strobe
   input  wire logic [`GPU_WORD_W-1:0] main_bus,
   input  wire logic                   clear_fifo,  // Flush, wins over push and pop
   input  wire logic                   pop,
   output logic      [`GPU_WORD_W-1:0] head,        // Oldest word
   output logic                        not_empty,
   output logic                        full
);
   localparam int ptr_w = $clog2(`GPU_FIFO_DEPTH);

   logic [`GPU_WORD_W-1:0] mem [`GPU_FIFO_DEPTH];
   logic [ptr_w-1:0]       wr_ptr;
   logic [ptr_w-1:0]       rd_ptr;
   logic [ptr_w:0]         count;                  // One extra bit for full
   logic                   push;
   logic                   pull;

   assign push      = to_gp0 & (main_bus != {24'd0, `GP0_NOP_NB}) & ~full; // Nop word dropped
   assign pull      = pop & not_empty;
   assign not_empty = (count != '0);
   assign full      = (count == `GPU_FIFO_DEPTH);
   assign head      = mem[rd_ptr];

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear_fifo) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;        // Wraps at depth
         if (pull) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pull})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                             // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= main_bus;
   end

endmodule
`default_nettype wire

/* source/gpu_control.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module gpu_control import gpu_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   to_gp1,      // GP1 write strobe
   input  wire logic [`GPU_WORD_W-1:0] main_bus,
   input  wire logic                   fifo_full,
   input  wire logic                   irq_req,
   input  wire draw_env_t              draw_env,
   output logic                        clear_fifo,  // GP1 00 or 01
   output logic                        soft_rst,    // GP1 00
   output gpu_status_t                 gpu_stat,
   output logic      [`GPU_WORD_W-1:0] gpu_read
);
   localparam gpu_status_t stat_rst = `GPU_STATUS_RST;

   gpu_status_t         stat_q;                    // Only GP1 owned fields change
   logic [7:0]          op;

   assign op         = main_bus[31:24];
   assign soft_rst   = to_gp1 & (op == `GP1_RST);
   assign clear_fifo = to_gp1 & ((op == `GP1_RST) | (op == `GP1_RST_CMDBUF));

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         stat_q <= stat_rst;
      end else if (soft_rst) begin
         stat_q <= stat_rst;
      end else begin
         if (irq_req) stat_q.irq <= 1'b1;
         if (to_gp1) begin
            case (op)
               `GP1_RST_CMDBUF: ;                  // FIFO flush only
               `GP1_ACKINT:     stat_q.irq         <= 1'b0; // Wins over a new request
               `GP1_DIS:        stat_q.display_off <= main_bus[0];
               `GP1_DMADIR:     stat_q.dma_dir     <= main_bus[1:0];
               `GP1_DIS_MODE: begin
                  {stat_q.interlace, stat_q.depth, stat_q.video_mode,
                   stat_q.vres, stat_q.hres1} <= main_bus[5:0]; // Status 22:17
                  stat_q.hres2   <= main_bus[6];
                  stat_q.reverse <= main_bus[7];
               end
               default: ;
            endcase
         end
      end
   end

   // Read register, loaded from draw_env as it stands at the write edge
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         gpu_read <= '0;
      end else if (to_gp1 && op == `GP1_GETINFO) begin
         case (main_bus[3:0])
            `GPU_INFO_TL:   gpu_read <= {12'd0, draw_env.area_tl}; // x + y<<10
            `GPU_INFO_BR:   gpu_read <= {12'd0, draw_env.area_br};
            `GPU_INFO_OFS:  gpu_read <= {10'd0, draw_env.offset};  // x + y<<11
            `GPU_INFO_VER:  gpu_read <= `GPU_VERSION;
            `GPU_INFO_ZERO: gpu_read <= '0;
            default:        ;                      // Keep last answer
         endcase
      end
   end

   always_comb begin
      gpu_stat          = stat_q;
      gpu_stat.cmd_rdy  = ~fifo_full;
      gpu_stat.text_off = draw_env.text_off;
      gpu_stat.mask_en  = draw_env.mask_en;
      gpu_stat.set_mask = draw_env.set_mask;
      gpu_stat[10:0]    = draw_env.draw_bits;      // Draw mode from GP0 E1
   end

endmodule
`default_nettype wire

/* source/gpu_macros.svh */
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// Bus and storage sizes
`define GPU_WORD_W      32             // CPU bus word
`define GPU_FIFO_DEPTH  16             // GP0 command FIFO entries
`define GPU_X_W         10             // VRAM x, 0 to 1023
`define GPU_Y_W         9              // VRAM y, 0 to 511
`define GPU_OFS_W       11             // Draw offset coordinate
`define GPU_ADDR_W      19             // Halfword address, y*1024 + x

`define GPU_STATUS_RST  32'h14802000   // Status word out of reset
`define GPU_VERSION     32'd2          // GETINFO 7 answer

// GP0 opcodes, bits 31:24 of the word
`define GP0_NOP_NB      8'h00          // Never enters the FIFO
`define GP0_FILRECT     8'h02          // Fill VRAM rectangle
`define GP0_NOP         8'h03
`define GP0_INTREQ      8'h1F          // Raise GPU irq
`define GP0_DRWMODE     8'hE1          // Draw mode bits
`define GP0_DRWWND_TL   8'hE3          // Draw area top-left
`define GP0_DRWWND_BR   8'hE4          // Draw area bottom-right
`define GP0_DRWWND_OS   8'hE5          // Draw offset
`define GP0_MSK         8'hE6          // Mask bit handling

// GP1 opcodes
`define GP1_RST         8'h00          // Full GPU reset
`define GP1_RST_CMDBUF  8'h01          // Flush command FIFO
`define GP1_ACKINT      8'h02          // Clear irq
`define GP1_DIS         8'h03          // Display off bit
`define GP1_DMADIR      8'h04
`define GP1_DIS_TL      8'h05          // Display start in VRAM
`define GP1_DIS_MODE    8'h08          // Resolution and video mode
`define GP1_GETINFO     8'h10          // Load read register

// GETINFO selectors, bits 3:0
`define GPU_INFO_TL     4'h3
`define GPU_INFO_BR     4'h4
`define GPU_INFO_OFS    4'h5
`define GPU_INFO_VER    4'h7
`define GPU_INFO_ZERO   4'h8

`endif

/* source/gpu_pkg.sv */
`default_nettype none
`include "gpu_macros.svh"

package gpu_pkg;

   // GPUSTAT as read by the CPU, msb first
   typedef struct packed {
      logic       odd_line;
      logic [1:0] dma_dir;
      logic       dma_rdy;
      logic       vram_send_rdy;
      logic       cmd_rdy;          // FIFO has room
      logic       dma_req;
      logic       irq;
      logic       display_off;
      logic       interlace;
      logic       depth;            // 24-bit display when set
      logic       video_mode;
      logic       vres;
      logic [1:0] hres1;
      logic       hres2;
      logic       text_off;
      logic       reverse;
      logic       field;
      logic       mask_en;
      logic       set_mask;
      logic       draw_to_display;
      logic       dither;
      logic [1:0] text_mode;
      logic [1:0] semi_mode;
      logic       text_y;
      logic [3:0] text_x;           // Texture page x base
   } gpu_status_t;

   // y above x, so the packed value is y shifted by the x width
   typedef struct packed {
      logic [`GPU_X_W-1:0] y;
      logic [`GPU_X_W-1:0] x;
   } area_pt_t;

   typedef struct packed {
      logic [`GPU_OFS_W-1:0] y;
      logic [`GPU_OFS_W-1:0] x;
   } offset_t;

   typedef struct packed {
      logic        text_off;
      logic        set_mask;
      logic        mask_en;
      logic [10:0] draw_bits;       // Mirrors status 10:0
      area_pt_t    area_tl;
      area_pt_t    area_br;
      offset_t     offset;
   } draw_env_t;

   typedef struct packed {
      logic [`GPU_X_W-1:0] x;
      logic [`GPU_Y_W-1:0] y;
      logic [`GPU_X_W-1:0] width;
      logic [`GPU_Y_W-1:0] height;
      logic [14:0]         color;   // b g r, 5 bits each
   } fill_job_t;

   typedef struct packed {
      logic [`GPU_ADDR_W-1:0] addr;
      logic [15:0]            data;
   } vram_px_t;

endpackage
`default_nettype wire

/* source/gpu_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module gpu_top import gpu_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   to_gp0,
   input  wire logic                   to_gp1,
   input  wire logic [`GPU_WORD_W-1:0] main_bus,  // Shared by both ports
   output gpu_status_t                 gpu_stat,
   output logic      [`GPU_WORD_W-1:0] gpu_read,
   output vram_px_t                    vram_px,
   output logic                        vram_we,
   input  wire logic                   vram_rdy
);
   logic [`GPU_WORD_W-1:0] fifo_head;
   logic                   fifo_not_empty;
   logic                   fifo_full;
   logic                   fifo_pop;
   logic                   clear_fifo;            // Flush FIFO, decoder and fill
   logic                   soft_rst;
   logic                   irq_req;
   draw_env_t              draw_env;
   fill_job_t              job;
   logic                   job_valid;
   logic                   job_ready;

   gpu_control u_control (
      .clk        (clk),
      .rst        (rst),
      .to_gp1     (to_gp1),
      .main_bus   (main_bus),
      .fifo_full  (fifo_full),
      .irq_req    (irq_req),
      .draw_env   (draw_env),
      .clear_fifo (clear_fifo),
      .soft_rst   (soft_rst),
      .gpu_stat   (gpu_stat),
      .gpu_read   (gpu_read)
   );

   gp0_fifo u_fifo (
      .clk        (clk),
      .rst        (rst),
      .to_gp0     (to_gp0),
      .main_bus   (main_bus),
      .clear_fifo (clear_fifo),
      .pop        (fifo_pop),
      .head       (fifo_head),
      .not_empty  (fifo_not_empty),
      .full       (fifo_full)
   );

   gp0_decoder u_decoder (
      .clk        (clk),
      .rst        (rst),
      .clear_fifo (clear_fifo),
      .soft_rst   (soft_rst),
      .head       (fifo_head),
      .not_empty  (fifo_not_empty),
      .pop        (fifo_pop),
      .irq_req    (irq_req),
      .draw_env   (draw_env),
      .job        (job),
      .job_valid  (job_valid),
      .job_ready  (job_ready)
   );

   vram_fill u_fill (
      .clk        (clk),
      .rst        (rst),
      .clear_fifo (clear_fifo),
      .job        (job),
      .job_valid  (job_valid),
      .job_ready  (job_ready),
      .vram_px    (vram_px),
      .vram_we    (vram_we),
      .vram_rdy   (vram_rdy)
   );

endmodule
`default_nettype wire

/* source/vram_fill.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module vram_fill import gpu_pkg::*; (
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      clear_fifo,  // Aborts the running fill
   input  wire fill_job_t job,
   input  wire logic      job_valid,
   output logic           job_ready,
   output vram_px_t       vram_px,
   output logic           vram_we,     // Valid toward VRAM
   input  wire logic      vram_rdy
);
   fill_job_t           job_q;
   logic                busy;
   logic [`GPU_X_W-1:0] col;                       // Offset inside the row
   logic [`GPU_Y_W-1:0] row;
   logic                take;
   logic                step;
   logic                last_col;
   logic                last_row;
   logic                empty_job;

   assign job_ready = ~busy;
   assign take      = job_valid & job_ready & ~clear_fifo;
   assign empty_job = (job.width == '0) | (job.height == '0);
   assign step      = busy & vram_rdy;             // One pixel per handshake
   assign last_col  = (col == job_q.width - 1'b1);
   assign last_row  = (row == job_q.height - 1'b1);

   assign vram_we = busy;
   // Self-sized sums wrap at 1024 in x and 512 in y
   assign vram_px = '{addr: {job_q.y + row, job_q.x + col},
                      data: {1'b0, job_q.color}};

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
         col  <= '0;
         row  <= '0;
      end else if (clear_fifo) begin
         busy <= 1'b0;
         col  <= '0;
         row  <= '0;
      end else if (take) begin
         busy <= ~empty_job;                       // Empty job frees at once
         col  <= '0;
         row  <= '0;
      end else if (step) begin
         if (last_col) begin
            col <= '0;
            if (last_row) busy <= 1'b0;            // Ready again next cycle
            else          row  <= row + 1'b1;
         end else begin
            col <= col + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) job_q <= job;
   end

endmodule
`default_nettype wire

/* verif/gpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module gpu_tb import gpu_pkg::*; ();
   localparam int clk_period    = 10;
   localparam int n_gp1         = 40;              // Random GP1 commands
   localparam int n_env_groups  = 5;
   localparam int n_env_words   = 8;               // Commands per group
   localparam int n_info_rounds = 4;
   localparam int n_fills       = 20;
   localparam int max_px        = 36;              // 6 by 6 rectangle
   localparam int drain_cycles  = `GPU_FIFO_DEPTH + 4;
   localparam int watch_ops     = 1 + n_gp1 + n_env_groups * n_env_words
                                  + n_info_rounds * 9 + 2 + n_fills * 3;
   localparam int watch_cycles  = watch_ops * 30 + n_fills * max_px * 4;
   localparam gpu_status_t stat_rst = `GPU_STATUS_RST;
   localparam logic [7:0] gp1_ops [6] = '{`GP1_RST, `GP1_ACKINT, `GP1_DIS,
                                          `GP1_DMADIR, `GP1_DIS_TL, `GP1_DIS_MODE};
   // Selector 0 comes right after the version, so a kept answer is nonzero
   localparam logic [3:0] info_sels [6] = '{`GPU_INFO_TL, `GPU_INFO_BR, `GPU_INFO_OFS,
                                            `GPU_INFO_ZERO, `GPU_INFO_VER, 4'h0};

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   to_gp0;
   logic                   to_gp1;
   logic [`GPU_WORD_W-1:0] main_bus;
   gpu_status_t            gpu_stat;
   logic [`GPU_WORD_W-1:0] gpu_read;
   vram_px_t               vram_px;
   logic                   vram_we;
   logic                   vram_rdy;

   logic [31:0]  rng;                              // Xorshift state
   logic         rdy_rand;                         // Random back-pressure on
   gpu_status_t  m_stat;                           // GP1 owned fields
   logic [10:0]  m_draw;                           // Status 10:0
   logic         m_text_off;
   logic         m_set_mask;
   logic         m_mask_en;
   logic [9:0]   m_tl_x;
   logic [9:0]   m_tl_y;
   logic [9:0]   m_br_x;
   logic [9:0]   m_br_y;
   logic [10:0]  m_ofs_x;
   logic [10:0]  m_ofs_y;
   logic [31:0]  m_read;
   vram_px_t     px_q[$];                          // Pixels still due

   gpu_top uut (
      .clk      (clk),
      .rst      (rst),
      .to_gp0   (to_gp0),
      .to_gp1   (to_gp1),
      .main_bus (main_bus),
      .gpu_stat (gpu_stat),
      .gpu_read (gpu_read),
      .vram_px  (vram_px),
      .vram_we  (vram_we),
      .vram_rdy (vram_rdy)
   );

   always #(clk_period / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Status as the host should read it with the FIFO not full
   function automatic gpu_status_t expected_status();
      gpu_status_t s;
      s          = m_stat;
      s.cmd_rdy  = 1'b1;
      s.text_off = m_text_off;
      s.set_mask = m_set_mask;
      s.mask_en  = m_mask_en;
      {s.draw_to_display, s.dither, s.text_mode, s.semi_mode, s.text_y, s.text_x} = m_draw;
      return s;
   endfunction

   task automatic check_status(input gpu_status_t got, input gpu_status_t exp,
                               input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s, status %h expected %h", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1, "status mismatch");
      end
   endtask

   task automatic check_read(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s, read %h expected %h", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1, "read register mismatch");
      end
   endtask

   task automatic check_px(input vram_px_t got, input vram_px_t exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s, pixel %h expected %h", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1, "pixel mismatch");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %b expected %b", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   // One clock, strobes dropped on the falling edge
   task automatic next_cycle();
      logic [31:0] r;
      @(negedge clk);
      to_gp0 = 1'b0;
      to_gp1 = 1'b0;
      if (rdy_rand) begin
         r        = next_rand();
         vram_rdy = r[0];                          // 50% ready
      end
   endtask

   task automatic write_gp0(input logic [31:0] w);
      next_cycle();
      while (!gpu_stat.cmd_rdy) next_cycle();      // Never write into a full FIFO
      to_gp0   = 1'b1;
      main_bus = w;
   endtask

   task automatic write_gp1(input logic [31:0] w);
      next_cycle();
      to_gp1   = 1'b1;
      main_bus = w;
   endtask

   task automatic model_gp1(input logic [31:0] w);
      case (w[31:24])
         `GP1_RST: begin
            m_stat     = stat_rst;                 // Area and offset kept
            m_draw     = '0;
            m_text_off = 1'b0;
            m_set_mask = 1'b0;
            m_mask_en  = 1'b0;
         end
         `GP1_ACKINT: m_stat.irq         = 1'b0;
         `GP1_DIS:    m_stat.display_off = w[0];
         `GP1_DMADIR: m_stat.dma_dir     = w[1:0];
         `GP1_DIS_MODE: begin
            {m_stat.interlace, m_stat.depth, m_stat.video_mode,
             m_stat.vres, m_stat.hres1} = w[5:0];
            m_stat.hres2   = w[6];
            m_stat.reverse = w[7];
         end
         `GP1_GETINFO: begin
            case (w[3:0])
               `GPU_INFO_TL:   m_read = 32'(m_tl_x) + (32'(m_tl_y) << 10);
               `GPU_INFO_BR:   m_read = 32'(m_br_x) + (32'(m_br_y) << 10);
               `GPU_INFO_OFS:  m_read = 32'(m_ofs_x) + (32'(m_ofs_y) << 11);
               `GPU_INFO_VER:  m_read = `GPU_VERSION;
               `GPU_INFO_ZERO: m_read = '0;
               default:        ;                   // Old answer stays
            endcase
         end
         default: ;                                // Display start not visible
      endcase
   endtask

   task automatic model_gp0(input logic [31:0] w);
      case (w[31:24])
         `GP0_DRWMODE: begin
            m_draw     = w[10:0];
            m_text_off = w[11];
         end
         `GP0_MSK: begin
            m_set_mask = w[0];
            m_mask_en  = w[1];
         end
         `GP0_INTREQ: m_stat.irq = 1'b1;
         `GP0_DRWWND_TL: begin
            m_tl_x = w[9:0];
            m_tl_y = w[19:10];
         end
         `GP0_DRWWND_BR: begin
            m_br_x = w[9:0];
            m_br_y = w[19:10];
         end
         `GP0_DRWWND_OS: begin
            m_ofs_x = w[10:0];
            m_ofs_y = w[21:11];
         end
         default: ;                                // Nops
      endcase
   endtask

   // GP0 command given time to execute alone
   task automatic env_cmd(input logic [31:0] w);
      write_gp0(w);
      model_gp0(w);
      repeat (3) next_cycle();
   endtask

   task automatic gp1_cmd(input logic [31:0] w);
      write_gp1(w);
      model_gp1(w);
      next_cycle();                                // Result registered by now
   endtask

   task automatic drain();
      repeat (drain_cycles) next_cycle();
   endtask

   // Expected pixels, row by row, wrapping at 1024 by 512
   task automatic queue_fill(input logic [23:0] color, input logic [9:0] x,
                             input logic [8:0] y, input logic [9:0] w, input logic [8:0] h);
      vram_px_t p;
      for (int row = 0; row < int'(h); row++) begin
         for (int col = 0; col < int'(w); col++) begin
            p.addr = {y + 9'(row), x + 10'(col)};
            p.data = {1'b0, color[23:19], color[15:11], color[7:3]};
            px_q.push_back(p);
         end
      end
   endtask

   // Every VRAM handshake must match the next expected pixel
   always @(posedge clk) begin
      if (!rst && vram_we && vram_rdy) begin
         if (px_q.size() == 0) begin
            $display("Unexpected VRAM write at %0t ns, no pixel was due", $time);
            $display("Checks failed");
            $fatal(1, "extra VRAM write");
         end else begin
            check_px(vram_px, px_q.pop_front(), "VRAM write");
         end
      end
   end

   initial begin
      #(watch_cycles * clk_period);
      $display("Timeout after %0d cycles, the run did not finish", watch_cycles);
      $display("Checks failed");
      $fatal(1, "watchdog");
   end

   initial begin
      logic [31:0] r;
      logic [31:0] r2;
      logic [31:0] r3;
      int          kind;
      logic [9:0]  fx;
      logic [8:0]  fy;
      logic [9:0]  fw;
      logic [8:0]  fh;
      rst        = 1'b1;
      to_gp0     = 1'b0;
      to_gp1     = 1'b0;
      main_bus   = '0;
      vram_rdy   = 1'b1;
      rdy_rand   = 1'b0;
      rng        = 32'h69a4;
      m_stat     = stat_rst;
      m_draw     = '0;
      m_text_off = 1'b0;
      m_set_mask = 1'b0;
      m_mask_en  = 1'b0;
      m_tl_x     = '0;
      m_tl_y     = '0;
      m_br_x     = '0;
      m_br_y     = '0;
      m_ofs_x    = '0;
      m_ofs_y    = '0;
      m_read     = '0;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      next_cycle();

      check_status(gpu_stat, expected_status(), "after reset");
      check_read(gpu_read, 32'd0, "after reset");
      check_flag(vram_we, 1'b0, "vram_we after reset");

      for (int i = 0; i < n_gp1; i++) begin          // GP1 commands one by one
         r    = next_rand();
         kind = int'(r[31:24]) % 6;
         gp1_cmd({gp1_ops[kind], r[23:0]});
         check_status(gpu_stat, expected_status(), "GP1 command");
      end

      for (int g = 0; g < n_env_groups; g++) begin   // Draw mode, mask, irq
         for (int i = 0; i < n_env_words; i++) begin
            r    = next_rand();
            kind = int'(r[31:24]) % 6;
            case (kind)
               0:       env_cmd({`GP0_DRWMODE, r[23:0]});
               1:       env_cmd({`GP0_MSK, r[23:0]});
               2:       env_cmd({`GP0_INTREQ, r[23:0]});
               3:       env_cmd({`GP0_NOP, r[23:0]});
               4:       env_cmd(32'h0);              // Unbuffered nop
               default: gp1_cmd({`GP1_ACKINT, r[23:0]});
            endcase
         end
         drain();
         check_status(gpu_stat, expected_status(), "after GP0 group");
      end

      for (int k = 0; k < n_info_rounds; k++) begin  // Area, offset, GETINFO
         r = next_rand();
         env_cmd({`GP0_DRWWND_TL, r[23:0]});
         r = next_rand();
         env_cmd({`GP0_DRWWND_BR, r[23:0]});
         r = next_rand();
         env_cmd({`GP0_DRWWND_OS, r[23:0]});
         drain();
         for (int i = 0; i < 6; i++) begin
            gp1_cmd({`GP1_GETINFO, 20'd0, info_sels[i]});
            check_read(gpu_read, m_read, "GETINFO");
         end
      end
      gp1_cmd({`GP1_RST, 24'd0});
      check_status(gpu_stat, expected_status(), "after GP1 reset");
      gp1_cmd({`GP1_GETINFO, 20'd0, `GPU_INFO_TL});
      check_read(gpu_read, m_read, "area after GP1 reset");

      rdy_rand = 1'b1;
      for (int i = 0; i < n_fills; i++) begin        // Fill rectangles
         r  = next_rand();
         r2 = next_rand();
         r3 = next_rand();
         fw = {2'd0, r[7:0] % 8'd7};
         fh = {1'b0, r[15:8] % 8'd7};
         if (i % 4 == 3) begin
            fx = 10'd1021 + {8'd0, r2[1:0]};         // Near the wrap edges
            fy = 9'd509 + {7'd0, r2[11:10]};
         end else begin
            fx = r2[9:0];
            fy = r2[18:10];
         end
         queue_fill(r3[23:0], fx, fy, fw, fh);
         write_gp0({`GP0_FILRECT, r3[23:0]});
         write_gp0({7'd0, fy, 6'd0, fx});
         write_gp0({7'd0, fh, 6'd0, fw});
      end
      next_cycle();
      while (px_q.size() != 0) next_cycle();
      drain();                                     // Extra writes caught here
      rdy_rand = 1'b0;

      $display("All checks passed");
      $finish;
   end

endmodule
`default_nettype wire
